// File: cpu_cfg.svh
// Core sizing macros for the three-stage core, included by the packages and the RTL that size from them
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data path width
`define CPU_DATA_W 16

// Register file depth and its index width
`define CPU_REG_N  8
`define CPU_REG_AW 3

// Major opcode field, instr[15:11]
`define CPU_OPC_W  5

`endif

// File: isa_pkg.sv
// Instruction-set types of the 16-bit core, imported by every stage that looks at instruction fields
`include "cpu_cfg.svh"

package isa_pkg;

	typedef logic [`CPU_DATA_W-1:0] word_t;
	typedef logic [`CPU_REG_AW-1:0] reg_idx_t;
	typedef logic [1:0] funct_t;
	typedef logic [4:0] imm5_t;
	typedef logic [7:0] imm8_t;

	// Kept major opcodes, anything else decodes as illegal
	typedef enum logic [`CPU_OPC_W-1:0] {
		OP_NOP   = 5'b00001,
		OP_ADDI  = 5'b01000,
		OP_SUBI  = 5'b01001,
		OP_XORI  = 5'b01010,
		OP_ANDNI = 5'b01011,
		OP_SLBI  = 5'b10010,
		OP_ROLI  = 5'b10100,
		OP_SLLI  = 5'b10101,
		OP_RORI  = 5'b10110,
		OP_SRLI  = 5'b10111,
		OP_LBI   = 5'b11000,
		OP_BTR   = 5'b11001,
		OP_SHF   = 5'b11010,   // ROL, SLL, ROR, SRL by funct
		OP_ALU   = 5'b11011,   // ADD, SUB, XOR, ANDN by funct
		OP_SEQ   = 5'b11100,
		OP_SLT   = 5'b11101,
		OP_SLE   = 5'b11110,
		OP_SCO   = 5'b11111
	} opcode_t;

endpackage

// File: pipe_pkg.sv
// Pipeline bundle types passed between decode, execute and result stages
package pipe_pkg;
	import isa_pkg::*;

	// Low eight values follow the funct order of the two register groups
	typedef enum logic [3:0] {
		UOP_ADD, UOP_SUBR, UOP_XOR, UOP_ANDN,
		UOP_ROL, UOP_SLL, UOP_ROR, UOP_SRL,
		UOP_SEQ, UOP_SLT, UOP_SLE, UOP_SCO,
		UOP_LBI, UOP_SLBI, UOP_BTR, UOP_PASS
	} uop_t;

	typedef struct packed {
		uop_t     uop;
		word_t    opa;
		word_t    opb;
		reg_idx_t dest;
		logic     write;
		logic     illegal;
	} dec_t;

	typedef struct packed {
		reg_idx_t dest;
		logic     write;
		logic     illegal;
		word_t    result;
	} exe_t;

	typedef struct packed {
		logic     we;
		reg_idx_t dest;
		word_t    data;
	} wb_t;

endpackage

// File: stage_if.sv
// Valid-plus-payload channel between pipeline stages, one instance per pipeline register
`timescale 1ns/1ns

interface stage_if #(
	parameter type T = logic
);
	logic valid;
	T     payload;

	// Producing stage owns both signals
	modport src (
		output valid,
		output payload
	);

	modport dst (
		input valid,
		input payload
	);

endinterface

// File: insn_decode.sv
// Decode stage that splits each instruction into a micro-op with forwarded operands and feeds execute
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module insn_decode (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              instr_valid,
	input  isa_pkg::word_t    instr,
	input  pipe_pkg::wb_t     ex_fwd,
	input  pipe_pkg::wb_t     rf_wr,
	input  isa_pkg::word_t    rd_data_a,
	input  isa_pkg::word_t    rd_data_b,
	output isa_pkg::reg_idx_t rd_sel_a,
	output isa_pkg::reg_idx_t rd_sel_b,
	stage_if.src              dec_bus
);
	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_t  opc;
	funct_t   fn;
	reg_idx_t rs_f;
	reg_idx_t rt_f;
	reg_idx_t rd_f;
	imm5_t    imm5;
	imm8_t    imm8;
	word_t    opa;
	word_t    fwd_b;
	word_t    opb;
	reg_idx_t dest;
	uop_t     uop;
	logic     ill;
	logic     wr;

	// Youngest producer wins over the pending write and the file
	function automatic word_t fwd(input reg_idx_t idx, input word_t rf_val,
			input wb_t ex, input wb_t rw);
		if (ex.we && ex.dest == idx)
			return ex.data;
		if (rw.we && rw.dest == idx)
			return rw.data;
		return rf_val;
	endfunction

	assign opc  = opcode_t'(instr[15:11]);
	assign rs_f = instr[10:8];
	assign rt_f = instr[7:5];
	assign rd_f = instr[4:2];
	assign fn   = instr[1:0];
	assign imm5 = instr[4:0];
	assign imm8 = instr[7:0];

	assign rd_sel_a = rs_f;
	assign rd_sel_b = rt_f;
	assign opa      = fwd(rs_f, rd_data_a, ex_fwd, rf_wr);
	assign fwd_b    = fwd(rt_f, rd_data_b, ex_fwd, rf_wr);

	// Destination field depends on format
	always_comb begin
		case (opc)
			OP_LBI, OP_SLBI: dest = rs_f;
			OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
			OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: dest = rt_f;
			default: dest = rd_f;
		endcase
	end

	// Operand b is an immediate or Rt
	always_comb begin
		case (opc)
			OP_ADDI, OP_SUBI: opb = {{(`CPU_DATA_W-5){imm5[4]}}, imm5};
			OP_XORI, OP_ANDNI, OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI:
				opb = {{(`CPU_DATA_W-5){1'b0}}, imm5};
			OP_LBI, OP_SLBI: opb = {{(`CPU_DATA_W-8){1'b0}}, imm8};
			default: opb = fwd_b;
		endcase
	end

	always_comb begin
		uop = UOP_PASS;
		ill = 1'b0;
		case (opc)
			OP_ADDI:  uop = UOP_ADD;
			OP_SUBI:  uop = UOP_SUBR;
			OP_XORI:  uop = UOP_XOR;
			OP_ANDNI: uop = UOP_ANDN;
			OP_ROLI:  uop = UOP_ROL;
			OP_SLLI:  uop = UOP_SLL;
			OP_RORI:  uop = UOP_ROR;
			OP_SRLI:  uop = UOP_SRL;
			OP_ALU:   uop = uop_t'({2'b00, fn});
			OP_SHF:   uop = uop_t'({2'b01, fn});
			OP_SEQ:   uop = UOP_SEQ;
			OP_SLT:   uop = UOP_SLT;
			OP_SLE:   uop = UOP_SLE;
			OP_SCO:   uop = UOP_SCO;
			OP_LBI:   uop = UOP_LBI;
			OP_SLBI:  uop = UOP_SLBI;
			OP_BTR:   uop = UOP_BTR;
			OP_NOP:   uop = UOP_PASS;
			default:  ill = 1'b1;
		endcase
	end

	assign wr = !ill && (opc != OP_NOP);

	always_ff @(posedge clk) begin
		if (!rst_n)
			dec_bus.valid <= 1'b0;
		else
			dec_bus.valid <= instr_valid;
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			dec_bus.payload <= '{uop: uop, opa: opa, opb: opb, dest: dest,
				write: wr, illegal: ill};
		end
	end

	// Operands from the register file and both forwarding paths must be resolved
	a_opnd_known: assert property (@(posedge clk) disable iff (!rst_n)
		dec_bus.valid |-> !$isunknown(dec_bus.payload));

endmodule

// File: alu_execute.sv
// Execute stage: computes every kept result in one cycle and forwards it back to decode
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module alu_execute (
	input  logic          clk,
	input  logic          rst_n,
	stage_if.dst          dec_bus,
	stage_if.src          exe_bus,
	output pipe_pkg::wb_t ex_fwd
);
	import isa_pkg::*;
	import pipe_pkg::*;

	dec_t                      d;
	word_t                     a;
	word_t                     b;
	logic [3:0]                amt;
	logic [2*`CPU_DATA_W-1:0]  rot_l;
	logic [2*`CPU_DATA_W-1:0]  rot_r;
	logic [`CPU_DATA_W:0]      sum;
	word_t                     result;

	assign d   = dec_bus.payload;
	assign a   = d.opa;
	assign b   = d.opb;
	assign amt = b[3:0];

	// Rotates from a doubled word
	assign rot_l = {a, a} << amt;
	assign rot_r = {a, a} >> amt;

	// Shared adder, carry feeds SCO
	assign sum = {1'b0, a} + {1'b0, b};

	always_comb begin
		case (d.uop)
			UOP_ADD:  result = sum[`CPU_DATA_W-1:0];
			UOP_SUBR: result = b - a;
			UOP_XOR:  result = a ^ b;
			UOP_ANDN: result = a & ~b;
			UOP_ROL:  result = rot_l[2*`CPU_DATA_W-1:`CPU_DATA_W];
			UOP_SLL:  result = a << amt;
			UOP_ROR:  result = rot_r[`CPU_DATA_W-1:0];
			UOP_SRL:  result = a >> amt;
			UOP_SEQ:  result = word_t'(a == b);
			UOP_SLT:  result = word_t'($signed(a) < $signed(b));
			UOP_SLE:  result = word_t'($signed(a) <= $signed(b));
			UOP_SCO:  result = word_t'(sum[`CPU_DATA_W]);
			UOP_LBI:  result = {{(`CPU_DATA_W-8){b[7]}}, b[7:0]};
			UOP_SLBI: result = {a[`CPU_DATA_W-9:0], b[7:0]};
			UOP_BTR:  result = {<<{a}};
			default:  result = a;
		endcase
	end

	// Distance-one forwarding path into decode
	assign ex_fwd = '{we: dec_bus.valid && d.write, dest: d.dest, data: result};

	always_ff @(posedge clk) begin
		if (!rst_n)
			exe_bus.valid <= 1'b0;
		else
			exe_bus.valid <= dec_bus.valid;
	end

	always_ff @(posedge clk) begin
		if (dec_bus.valid) begin
			exe_bus.payload <= '{dest: d.dest, write: d.write, illegal: d.illegal,
				result: result};
		end
	end

	// Anything entering the result stage must be fully resolved
	a_exe_known: assert property (@(posedge clk) disable iff (!rst_n)
		exe_bus.valid |-> !$isunknown(exe_bus.payload.result));

endmodule

// File: writeback_result.sv
// Result stage: register file, pending-write bus for forwarding, and the retirement outputs
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module writeback_result (
	input  logic              clk,
	input  logic              rst_n,
	input  isa_pkg::reg_idx_t rd_sel_a,
	input  isa_pkg::reg_idx_t rd_sel_b,
	stage_if.dst              exe_bus,
	output isa_pkg::word_t    rd_data_a,
	output isa_pkg::word_t    rd_data_b,
	output pipe_pkg::wb_t     rf_wr,
	output logic              wb_valid,
	output logic              wb_write,
	output logic              err,
	output isa_pkg::reg_idx_t wb_reg,
	output isa_pkg::word_t    wb_data
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t regs [`CPU_REG_N];
	exe_t  x;

	assign x         = exe_bus.payload;
	assign rf_wr     = '{we: exe_bus.valid && x.write, dest: x.dest, data: x.result};
	assign rd_data_a = regs[rd_sel_a];
	assign rd_data_b = regs[rd_sel_b];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_REG_N; i++)
				regs[i] <= '0;
		end else if (rf_wr.we) begin
			regs[rf_wr.dest] <= rf_wr.data;
		end
	end

	// Retirement strobe, one per accepted instruction
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_write <= 1'b0;
			err      <= 1'b0;
		end else begin
			wb_valid <= exe_bus.valid;
			wb_write <= rf_wr.we;
			err      <= exe_bus.valid && x.illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (exe_bus.valid) begin
			wb_reg  <= x.dest;
			wb_data <= x.result;
		end
	end

	a_err_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		!(err && wb_write));

endmodule

// File: cpu_top.sv
// Top level of the three-stage core, the DUT seen by the testbench
`timescale 1ns/1ns

module cpu_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              instr_valid,
	input  isa_pkg::word_t    instr,
	output logic              wb_valid,
	output logic              wb_write,
	output isa_pkg::reg_idx_t wb_reg,
	output isa_pkg::word_t    wb_data,
	output logic              err
);
	import isa_pkg::*;
	import pipe_pkg::*;

	wb_t      ex_fwd;
	wb_t      rf_wr;
	reg_idx_t rd_sel_a;
	reg_idx_t rd_sel_b;
	word_t    rd_data_a;
	word_t    rd_data_b;

	stage_if #(.T(dec_t)) dec_bus ();
	stage_if #(.T(exe_t)) exe_bus ();

	insn_decode u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.ex_fwd      (ex_fwd),
		.rf_wr       (rf_wr),
		.rd_data_a   (rd_data_a),
		.rd_data_b   (rd_data_b),
		.rd_sel_a    (rd_sel_a),
		.rd_sel_b    (rd_sel_b),
		.dec_bus     (dec_bus.src)
	);

	alu_execute u_execute (
		.clk     (clk),
		.rst_n   (rst_n),
		.dec_bus (dec_bus.dst),
		.exe_bus (exe_bus.src),
		.ex_fwd  (ex_fwd)
	);

	writeback_result u_result (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_sel_a  (rd_sel_a),
		.rd_sel_b  (rd_sel_b),
		.exe_bus   (exe_bus.dst),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.rf_wr     (rf_wr),
		.wb_valid  (wb_valid),
		.wb_write  (wb_write),
		.err       (err),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data)
	);

endmodule

// File: tb_cpu_top.sv
// Self-checking testbench for cpu_top, replays cpu_cases.txt and checks every retirement pulse
`timescale 1ns/1ns

module tb_cpu_top;

	localparam int MAX_CASES  = 64;
	localparam int WAIT_LIMIT = 20;
	localparam int QUIET_CYC  = 8;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [15:0] instr;
	logic        wb_valid;
	logic        wb_write;
	logic [2:0]  wb_reg;
	logic [15:0] wb_data;
	logic        err;

	// Entry layout: tight flag, instruction, write flag, register, data, error bit
	logic [47:0] case_mem [MAX_CASES];
	int          n_cases;
	int          n_checked;
	int          errors;
	int          cycle = 0;
	integer      seed;
	int          pend_idx[$];
	int          pend_cycle[$];

	cpu_top DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_write    (wb_write),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data),
		.err         (err)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Rising edges seen so far
	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic load_cases();
		for (int i = 0; i < MAX_CASES; i++)
			case_mem[i] = '1;
		$readmemh("cpu_cases.txt", case_mem);
		n_cases = 0;
		// Unused slots keep the all-ones marker
		while (n_cases < MAX_CASES && case_mem[n_cases][47:44] != 4'hf)
			n_cases++;
	endtask

	task automatic drive_cases();
		int gap;
		for (int i = 0; i < n_cases; i++) begin
			// Tight entries follow the previous one with no idle cycle
			if (case_mem[i][44] == 1'b0) begin
				gap = {$random(seed)} % 3;
				instr_valid = 1'b0;
				repeat (gap) @(negedge clk);
			end
			instr_valid = 1'b1;
			instr       = case_mem[i][43:28];
			pend_idx.push_back(i);
			// Sampled at the next edge, retired two edges later
			pend_cycle.push_back(cycle + 3);
			@(negedge clk);
		end
		instr_valid = 1'b0;
	endtask

	task automatic compare_result(input int idx, input int due);
		logic        exp_write;
		logic [2:0]  exp_reg;
		logic [15:0] exp_data;
		logic        exp_err;
		exp_write = case_mem[idx][24];
		exp_reg   = case_mem[idx][22:20];
		exp_data  = case_mem[idx][19:4];
		exp_err   = case_mem[idx][0];
		n_checked++;
		if (cycle != due) begin
			$display("Case %0d retired at cycle %0d instead of cycle %0d", idx, cycle, due);
			errors++;
		end
		if (wb_write !== exp_write) begin
			$display("[FAIL] %0t wb_write got %0b expected %0b", $time, wb_write, exp_write);
			errors++;
		end
		if (err !== exp_err) begin
			$display("[FAIL] %0t err got %0b expected %0b", $time, err, exp_err);
			errors++;
		end
		// Register and data only mean something on a write
		if (exp_write) begin
			if (wb_reg !== exp_reg) begin
				$display("[FAIL] %0t wb_reg got %0d expected %0d", $time, wb_reg, exp_reg);
				errors++;
			end
			if (wb_data !== exp_data) begin
				$display("[FAIL] %0t wb_data got %h expected %h", $time, wb_data, exp_data);
				errors++;
			end
		end
	endtask

	task automatic check_results();
		int waited;
		int idx;
		int due;
		for (int k = 0; k < n_cases; k++) begin
			waited = 0;
			@(negedge clk);
			while (!wb_valid && waited < WAIT_LIMIT) begin
				waited++;
				@(negedge clk);
			end
			if (!wb_valid) begin
				$display("No result for case %0d within %0d cycles", k, WAIT_LIMIT);
				errors++;
				return;
			end
			if (pend_idx.size() == 0) begin
				$display("Result pulse at %0t with no instruction outstanding", $time);
				errors++;
			end else begin
				idx = pend_idx.pop_front();
				due = pend_cycle.pop_front();
				compare_result(idx, due);
			end
		end
	endtask

	// Pipeline must stay silent once every instruction has retired
	task automatic check_quiet();
		if (pend_idx.size() != 0) begin
			$display("%0d instructions never retired", pend_idx.size());
			errors++;
		end
		for (int i = 0; i < QUIET_CYC; i++) begin
			@(negedge clk);
			if (wb_valid) begin
				$display("Extra result pulse at %0t after the last instruction", $time);
				errors++;
			end
		end
	endtask

	initial begin
		seed        = 52705;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		errors      = 0;
		n_checked   = 0;
		load_cases();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		if (wb_valid || wb_write || err) begin
			$display("Retirement outputs not low after reset");
			errors++;
		end
		if (n_cases == 0) begin
			$display("No test cases were loaded from cpu_cases.txt");
			errors++;
		end
		fork
			drive_cases();
			check_results();
		join
		check_quiet();
		$display("Results checked: %0d of %0d, errors: %0d", n_checked, n_cases, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: cpu_cases.txt
// Columns: tight (1 = no idle cycle before it), instruction, expected write flag,
// expected register, expected data, expected error bit
0_c112_1_1_0012_0
0_9134_1_1_1234_0
0_c285_1_2_ff85_0
0_c37f_1_3_007f_0
0_93c0_1_3_7fc0_0
0_419f_1_4_1233_0
0_4aa3_1_5_007e_0
0_51df_1_6_122b_0
0_5af5_1_7_ff80_0
0_a184_1_4_2341_0
0_a9b3_1_5_91a0_0
0_b2c8_1_6_85ff_0
0_baec_1_7_000f_0
0_d970_1_4_91f4_0
0_d955_1_5_ed51_0
0_d95a_1_6_edb1_0
0_db3f_1_7_6dc0_0
0_d330_1_4_fc07_0
0_d237_1_5_0ff8_0
0_d139_1_6_2340_0
0_d13e_1_7_4123_0
0_c910_1_4_2c48_0
0_e134_1_5_0001_0
0_ea38_1_6_0001_0
0_f15c_1_7_0000_0
0_fa70_1_4_0001_0
0_c105_1_1_0005_0
1_4143_1_2_0008_0
1_d94c_1_3_000d_0
1_d970_1_4_0012_0
1_da85_1_1_000a_0
1_c140_1_1_0040_0
1_d934_1_5_0080_0
1_0800_0_0_0000_0
1_1234_0_0_0000_1
1_0014_0_0_0000_1
1_45c0_1_6_0080_0

// File: src.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
stage_if.sv
insn_decode.sv
alu_execute.sv
writeback_result.sv
cpu_top.sv
tb_cpu_top.sv

// File: Makefile
# Verilator flow for the three-stage core; variables can be set on the command line

VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_cpu_top
RTL_TOP   ?= cpu_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ns
PASS_MSG  := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
